// File: cfg_bus_pkg.sv
/*
  configuration bus types for the loop register slaves
  one request struct travels from the master to a slave and one response
  struct comes back, the address map below decodes the 2-bit register field
  shared by the register slaves, the clock generator, the top level and the
  testbench
*/
package cfg_bus_pkg;

  localparam int unsigned CFG_DATA_W = 32;  // register and bus data width
  localparam int unsigned CFG_ADDR_W = 2;   // four registers per loop

  // register map of one loop
  localparam logic [CFG_ADDR_W-1:0] ADDR_STATUS  = 2'd0;  // read only, {enable, lock}
  localparam logic [CFG_ADDR_W-1:0] ADDR_DIV     = 2'd1;  // divider value in the low bits
  localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL    = 2'd2;  // bit 0 enables the loop
  localparam logic [CFG_ADDR_W-1:0] ADDR_SCRATCH = 2'd3;  // free read/write word

  // request from the master, held stable while req is high until ack is seen
  typedef struct packed {
    logic                  req;   // level request
    logic                  wrn;   // high for write, low for read
    logic [CFG_ADDR_W-1:0] add;   // register address
    logic [CFG_DATA_W-1:0] data;  // write data
  } cfg_req_t;

  // response from the slave
  typedef struct packed {
    logic                  ack;     // single cycle acknowledge
    logic [CFG_DATA_W-1:0] r_data;  // read data, valid together with ack
    logic                  lock;    // loop lock flag, not tied to the handshake
  } cfg_rsp_t;

endpackage

// File: clk_gen_pkg.sv
/*
  constants of the emulated frequency-locked loops and the reset synchronizers
  widths and reset values of the divider registers, the lock settle count and
  the depth of the reset flop chain, plus the domain indices of the loop array
*/
package clk_gen_pkg;

  localparam int unsigned NUM_FLL     = 3;  // soc, peripheral and cluster loops
  localparam int unsigned FLL_SOC     = 0;
  localparam int unsigned FLL_PER     = 1;
  localparam int unsigned FLL_CLUSTER = 2;

  localparam int unsigned DIV_W = 8;  // divider field width

  localparam logic [DIV_W-1:0] DIV_RESET = 8'd1;  // divide by four after reset
  localparam logic             EN_RESET  = 1'b1;  // loops run straight out of reset

  // lock rises after this many full output periods without reconfiguration
  localparam int unsigned LOCK_CYCLES = 4;
  localparam int unsigned LOCK_CNT_W  = $clog2(LOCK_CYCLES + 1);

  localparam logic [LOCK_CNT_W-1:0] LOCK_TARGET = LOCK_CNT_W'(LOCK_CYCLES);

  // flops between the asynchronous reset and the released domain reset
  localparam int unsigned RST_SYNC_STAGES = 2;

endpackage

// File: fll_cfg_regs.sv
/*
  configuration register slave of one emulated loop
  a level request is answered with a one cycle ack one clock after it is
  first seen, read data comes with the ack and holds the value before any
  write, writes to the divider or control register restart the divider
*/
`timescale 1ns/1ps

module fll_cfg_regs (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  cfg_bus_pkg::cfg_req_t              cfg_i,
  input  logic                               lock_i,
  output cfg_bus_pkg::cfg_rsp_t              cfg_o,
  output logic [clk_gen_pkg::DIV_W-1:0]      div_o,
  output logic                               en_o,
  output logic                               restart_o
);

  logic                                  ack_q;
  logic [cfg_bus_pkg::CFG_DATA_W-1:0]    r_data_q;
  logic [cfg_bus_pkg::CFG_DATA_W-1:0]    rd_mux;
  logic [clk_gen_pkg::DIV_W-1:0]         div_q;
  logic                                  en_q;
  logic [cfg_bus_pkg::CFG_DATA_W-1:0]    scratch_q;
  logic                                  restart_q;
  logic                                  access;  // first edge of a new request
  logic                                  wr_en;

  assign access = cfg_i.req & ~ack_q;  // a request still high during ack is not re-served
  assign wr_en  = access & cfg_i.wrn;

  // read mux, sampled into r_data_q before the write lands
  always_comb begin
    rd_mux = '0;
    case (cfg_i.add)
      cfg_bus_pkg::ADDR_STATUS:  rd_mux = {30'd0, en_q, lock_i};
      cfg_bus_pkg::ADDR_DIV:     rd_mux = 32'(div_q);
      cfg_bus_pkg::ADDR_CTRL:    rd_mux = 32'(en_q);
      cfg_bus_pkg::ADDR_SCRATCH: rd_mux = scratch_q;
      default:                   rd_mux = '0;
    endcase
  end

  // handshake and control registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q     <= 1'b0;
      r_data_q  <= '0;
      div_q     <= clk_gen_pkg::DIV_RESET;
      en_q      <= clk_gen_pkg::EN_RESET;
      restart_q <= 1'b0;
    end else begin
      ack_q     <= access;
      restart_q <= 1'b0;
      if (access) r_data_q <= rd_mux;  // old value for writes as well
      if (wr_en && cfg_i.add == cfg_bus_pkg::ADDR_DIV) begin
        div_q     <= cfg_i.data[clk_gen_pkg::DIV_W-1:0];
        restart_q <= 1'b1;
      end
      if (wr_en && cfg_i.add == cfg_bus_pkg::ADDR_CTRL) begin
        en_q      <= cfg_i.data[0];
        restart_q <= 1'b1;  // enable changes also restart the lock count
      end
    end
  end

  // scratch word is plain payload
  always_ff @(posedge clk) begin
    if (wr_en && cfg_i.add == cfg_bus_pkg::ADDR_SCRATCH) scratch_q <= cfg_i.data;
  end

  assign cfg_o.ack    = ack_q;
  assign cfg_o.r_data = r_data_q;
  assign cfg_o.lock   = lock_i;  // lock is forwarded live, not sampled
  assign div_o        = div_q;
  assign en_o         = en_q;
  assign restart_o    = restart_q;  // pulses in the ack cycle

endmodule

// File: fll_clk_div.sv
/*
  programmable clock divider standing in for one frequency-locked loop
  the output toggles every div+1 reference cycles, so one output period is
  2*(div+1) cycles at 50% duty, lock follows once enough periods have passed
  since reset or the last restart, test mode passes the reference through
*/
`timescale 1ns/1ps

module fll_clk_div (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic                          test_mode_i,
  input  logic [clk_gen_pkg::DIV_W-1:0] div_i,
  input  logic                          en_i,
  input  logic                          restart_i,
  output logic                          clk_o,
  output logic                          lock_o
);

  logic [clk_gen_pkg::DIV_W-1:0]      half_cnt_q;  // reference cycles in the current half period
  logic                               clk_div_q;
  logic [clk_gen_pkg::LOCK_CNT_W-1:0] per_cnt_q;   // completed output periods, saturating
  logic                               toggle;

  // >= keeps a counter that ran past a freshly lowered divider from wrapping
  assign toggle = (half_cnt_q >= div_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      half_cnt_q <= '0;
      clk_div_q  <= 1'b0;
      per_cnt_q  <= '0;
    end else if (restart_i || !en_i) begin
      // a reconfiguration or a stopped loop starts over from a low output
      half_cnt_q <= '0;
      clk_div_q  <= 1'b0;
      per_cnt_q  <= '0;
    end else begin
      if (toggle) begin
        half_cnt_q <= '0;
        clk_div_q  <= ~clk_div_q;
        // a falling toggle closes one full output period
        if (clk_div_q && per_cnt_q != clk_gen_pkg::LOCK_TARGET) begin
          per_cnt_q <= per_cnt_q + 1'b1;
        end
      end else begin
        half_cnt_q <= half_cnt_q + 1'b1;
      end
    end
  end

  // in test mode the domain runs on the reference clock and counts as locked
  assign clk_o  = test_mode_i ? clk : clk_div_q;
  assign lock_o = test_mode_i | (per_cnt_q == clk_gen_pkg::LOCK_TARGET);

endmodule

// File: clk_gen.sv
/*
  array of three emulated loops for the soc, peripheral and cluster domains
  every domain pairs its own register slave with its own divider, so the
  loops share only the reference clock, the reset and test mode
*/
`timescale 1ns/1ps

module clk_gen (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  test_mode_i,
  input  cfg_bus_pkg::cfg_req_t soc_cfg_i,
  input  cfg_bus_pkg::cfg_req_t per_cfg_i,
  input  cfg_bus_pkg::cfg_req_t cluster_cfg_i,
  output cfg_bus_pkg::cfg_rsp_t soc_cfg_o,
  output cfg_bus_pkg::cfg_rsp_t per_cfg_o,
  output cfg_bus_pkg::cfg_rsp_t cluster_cfg_o,
  output logic                  soc_clk_o,
  output logic                  per_clk_o,
  output logic                  cluster_clk_o
);

  cfg_bus_pkg::cfg_req_t             cfg_req [clk_gen_pkg::NUM_FLL];
  cfg_bus_pkg::cfg_rsp_t             cfg_rsp [clk_gen_pkg::NUM_FLL];
  logic [clk_gen_pkg::NUM_FLL-1:0]   fll_clk;

  // domain ports mapped onto loop indices
  assign cfg_req[clk_gen_pkg::FLL_SOC]     = soc_cfg_i;
  assign cfg_req[clk_gen_pkg::FLL_PER]     = per_cfg_i;
  assign cfg_req[clk_gen_pkg::FLL_CLUSTER] = cluster_cfg_i;

  for (genvar d = 0; d < clk_gen_pkg::NUM_FLL; d++) begin : gen_fll
    logic [clk_gen_pkg::DIV_W-1:0] div;
    logic                          en;
    logic                          restart;
    logic                          lock;

    fll_cfg_regs i_cfg_regs (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .cfg_i     (cfg_req[d]),
      .lock_i    (lock),
      .cfg_o     (cfg_rsp[d]),
      .div_o     (div),
      .en_o      (en),
      .restart_o (restart)
    );

    fll_clk_div i_clk_div (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .test_mode_i (test_mode_i),
      .div_i       (div),
      .en_i        (en),
      .restart_i   (restart),
      .clk_o       (fll_clk[d]),
      .lock_o      (lock)
    );
  end

  assign soc_cfg_o     = cfg_rsp[clk_gen_pkg::FLL_SOC];
  assign per_cfg_o     = cfg_rsp[clk_gen_pkg::FLL_PER];
  assign cluster_cfg_o = cfg_rsp[clk_gen_pkg::FLL_CLUSTER];

  assign soc_clk_o     = fll_clk[clk_gen_pkg::FLL_SOC];
  assign per_clk_o     = fll_clk[clk_gen_pkg::FLL_PER];
  assign cluster_clk_o = fll_clk[clk_gen_pkg::FLL_CLUSTER];

endmodule

// File: rstgen.sv
/*
  reset synchronizer for one clock domain
  assertion follows the global reset at once, release waits for the chain
  to fill with ones on the domain clock, test mode bypasses the chain
*/
`timescale 1ns/1ps

module rstgen (
  input  logic clk_i,        // domain clock, may be stopped
  input  logic arst_n_i,
  input  logic test_mode_i,
  output logic rst_no
);

  logic [clk_gen_pkg::RST_SYNC_STAGES-1:0] sync_q;

  // ones shift in from the bottom, the top stage drives the domain reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[clk_gen_pkg::RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_no = test_mode_i ? arst_n_i : sync_q[clk_gen_pkg::RST_SYNC_STAGES-1];

endmodule

// File: soc_clk_rst_gen.sv
/*
  clock and reset block of the soc
  three emulated loops produce the soc, peripheral and cluster clocks from
  the reference clock and two synchronizers release the global reset into
  the soc and cluster domains, each loop has its own configuration port
*/
`timescale 1ns/1ps

module soc_clk_rst_gen (
  input  logic                  clk,            // reference clock
  input  logic                  arst_n_i,
  input  logic                  test_mode_i,
  input  cfg_bus_pkg::cfg_req_t soc_cfg_i,
  input  cfg_bus_pkg::cfg_req_t per_cfg_i,
  input  cfg_bus_pkg::cfg_req_t cluster_cfg_i,
  output cfg_bus_pkg::cfg_rsp_t soc_cfg_o,
  output cfg_bus_pkg::cfg_rsp_t per_cfg_o,
  output cfg_bus_pkg::cfg_rsp_t cluster_cfg_o,
  output logic                  clk_soc_o,
  output logic                  clk_per_o,
  output logic                  clk_cluster_o,
  output logic                  rstn_soc_sync_o,
  output logic                  rstn_cluster_sync_o
);

  clk_gen clk_gen_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .test_mode_i   (test_mode_i),
    .soc_cfg_i     (soc_cfg_i),
    .per_cfg_i     (per_cfg_i),
    .cluster_cfg_i (cluster_cfg_i),
    .soc_cfg_o     (soc_cfg_o),
    .per_cfg_o     (per_cfg_o),
    .cluster_cfg_o (cluster_cfg_o),
    .soc_clk_o     (clk_soc_o),
    .per_clk_o     (clk_per_o),
    .cluster_clk_o (clk_cluster_o)
  );

  // released on the soc clock, used by the always-on logic
  rstgen i_soc_rstgen (
    .clk_i       (clk_soc_o),
    .arst_n_i    (arst_n_i),
    .test_mode_i (test_mode_i),
    .rst_no      (rstn_soc_sync_o)
  );

  rstgen i_cluster_rstgen (
    .clk_i       (clk_cluster_o),  // the peripheral domain takes the soc reset
    .arst_n_i    (arst_n_i),
    .test_mode_i (test_mode_i),
    .rst_no      (rstn_cluster_sync_o)
  );

endmodule

// File: tb_checker.sv
/*
  checker of the clock and reset block testbench
  watches the configuration responses, the domain clocks and the synchronized
  resets, compares them with expected values handed over by the testbench top
  and prints one line per check plus a closing line with the counts
*/
`timescale 1ns/1ps

module tb_checker (
  input logic                  clk,
  input cfg_bus_pkg::cfg_rsp_t soc_cfg_i,
  input cfg_bus_pkg::cfg_rsp_t per_cfg_i,
  input cfg_bus_pkg::cfg_rsp_t cluster_cfg_i,
  input logic                  clk_soc_i,
  input logic                  clk_per_i,
  input logic                  clk_cluster_i,
  input logic                  rstn_soc_i,
  input logic                  rstn_cluster_i
);

  int                    pass_cnt = 0;
  int                    fail_cnt = 0;
  cfg_bus_pkg::cfg_rsp_t rsp [3];
  logic [2:0]            dom_clk;
  longint                last_rise [3] = '{0, 0, 0};
  longint                period_ns [3] = '{0, 0, 0};  // time between the last two rises
  int                    rise_cnt  [3] = '{0, 0, 0};
  bit                    armed = 1'b0;                 // a read compare waits for ack
  int                    arm_dom;
  logic [31:0]           arm_exp;
  logic [31:0]           arm_mask;
  string                 arm_name;

  assign rsp[0]  = soc_cfg_i;
  assign rsp[1]  = per_cfg_i;
  assign rsp[2]  = cluster_cfg_i;
  assign dom_clk = {clk_cluster_i, clk_per_i, clk_soc_i};

  // timestamps of domain clock rises, so test mode periods can be measured too
  for (genvar d = 0; d < 3; d++) begin : gen_rise
    always @(posedge dom_clk[d]) begin
      period_ns[d] = $time - last_rise[d];
      last_rise[d] = $time;
      rise_cnt[d]++;
    end
  end

  task automatic record_pass(input string name);
    pass_cnt++;
    $display("[PASS] %s", name);
  endtask

  task automatic note_failure(input string name, input string msg);
    fail_cnt++;
    $display("[FAIL] %s: %s", name, msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act === exp) record_pass(name);
    else begin
      fail_cnt++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // arms a read data compare for the next ack of one domain
  task automatic arm_read(input string name, input int dom, input logic [31:0] exp,
                          input logic [31:0] mask);
    arm_name = name;
    arm_dom  = dom;
    arm_exp  = exp;
    arm_mask = mask;
    armed    = 1'b1;
  endtask

  // r_data is registered, so it is stable at the edge that sees ack high
  always @(posedge clk) begin
    if (armed && rsp[arm_dom].ack) begin
      armed = 1'b0;
      check_value(arm_name, arm_exp & arm_mask, rsp[arm_dom].r_data & arm_mask);
    end
  end

  // waits for two fresh rises and compares the period in reference cycles
  task automatic measure_period(input string name, input int dom, input int exp);
    int start;
    int n;
    start = rise_cnt[dom];
    n     = 0;
    while (rise_cnt[dom] < start + 2 && n < 4 * exp + 64) begin
      @(negedge clk);
      n++;
    end
    if (rise_cnt[dom] < start + 2) note_failure(name, "domain clock did not toggle");
    else check_value(name, exp, 32'(period_ns[dom] / 10));
  endtask

  task automatic check_low(input string name, input int dom, input int cycles);
    int  start;
    bit  ok;
    start = rise_cnt[dom];
    ok    = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      if (dom_clk[dom] !== 1'b0) ok = 1'b0;
    end
    if (ok && rise_cnt[dom] == start) record_pass(name);
    else note_failure(name, "domain clock toggled while the loop was disabled");
  endtask

  // lock of one domain has to rise within a bounded number of reference cycles
  task automatic wait_lock(input string name, input int dom, input int limit);
    int n;
    n = 0;
    while (rsp[dom].lock !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (rsp[dom].lock === 1'b1) record_pass({name, "_lock"});
    else note_failure({name, "_lock"}, "lock did not rise in time");
  endtask

  // counts domain clock rises from reset release until each reset goes high
  task automatic check_reset_release(input string name);
    int s_soc;
    int s_cl;
    int d_soc;
    int d_cl;
    int n;
    s_soc = rise_cnt[0];
    s_cl  = rise_cnt[2];
    d_soc = -1;
    d_cl  = -1;
    n     = 0;
    while ((d_soc < 0 || d_cl < 0) && n < 64) begin
      @(negedge clk);
      n++;
      if (rstn_soc_i === 1'b1 && d_soc < 0) d_soc = rise_cnt[0] - s_soc;
      if (rstn_cluster_i === 1'b1 && d_cl < 0) d_cl = rise_cnt[2] - s_cl;
    end
    if (d_soc < 0) note_failure({name, "_soc"}, "soc reset was never released");
    else check_value({name, "_soc"}, clk_gen_pkg::RST_SYNC_STAGES, d_soc);
    if (d_cl < 0) note_failure({name, "_cluster"}, "cluster reset was never released");
    else check_value({name, "_cluster"}, clk_gen_pkg::RST_SYNC_STAGES, d_cl);
  endtask

  task automatic report();
    $display("checks finished: %0d passed, %0d failed", pass_cnt, fail_cnt);
  endtask

endmodule

// File: tb_soc_clk_rst_gen.sv
/*
  testbench of the clock and reset block
  applies a table of register accesses to the three loop ports, then checks
  the reset synchronizers and test mode, all comparing is done in tb_checker
*/
`timescale 1ns/1ps

module tb_soc_clk_rst_gen;

  localparam int CLK_NS     = 10;
  localparam int MAX_PERIOD = 12;  // longest divided period used in the table
  localparam int NUM_EXTRA  = 16;  // reset and test mode steps outside the table

  // post action after an access is 0 for none, 1 for lock then period and 2 for a low clock
  typedef struct {
    string       name;
    int          dom;
    bit          wr;
    logic [1:0]  add;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
    int          kind;  // 0 fixed expect, 1 random scratch write, 2 scratch readback
    int          post;
    int          period;
  } entry_t;

  logic                  clk;
  logic                  arst_n;
  logic                  test_mode;
  cfg_bus_pkg::cfg_req_t req [3];
  cfg_bus_pkg::cfg_rsp_t rsp [3];
  logic                  clk_soc;
  logic                  clk_per;
  logic                  clk_cluster;
  logic                  rstn_soc;
  logic                  rstn_cluster;
  entry_t                table_q [$];
  bit                    table_ready = 1'b0;
  logic [31:0]           lfsr_state  = 32'h13f8;
  logic [31:0]           scratch_exp [3];

  soc_clk_rst_gen soc_clk_rst_gen_i (
    .clk                 (clk),
    .arst_n_i            (arst_n),
    .test_mode_i         (test_mode),
    .soc_cfg_i           (req[0]),
    .per_cfg_i           (req[1]),
    .cluster_cfg_i       (req[2]),
    .soc_cfg_o           (rsp[0]),
    .per_cfg_o           (rsp[1]),
    .cluster_cfg_o       (rsp[2]),
    .clk_soc_o           (clk_soc),
    .clk_per_o           (clk_per),
    .clk_cluster_o       (clk_cluster),
    .rstn_soc_sync_o     (rstn_soc),
    .rstn_cluster_sync_o (rstn_cluster)
  );

  tb_checker checker_i (
    .clk            (clk),
    .soc_cfg_i      (rsp[0]),
    .per_cfg_i      (rsp[1]),
    .cluster_cfg_i  (rsp[2]),
    .clk_soc_i      (clk_soc),
    .clk_per_i      (clk_per),
    .clk_cluster_i  (clk_cluster),
    .rstn_soc_i     (rstn_soc),
    .rstn_cluster_i (rstn_cluster)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // worst entry is an access, a lock wait and a period measurement
  initial begin
    wait (table_ready);
    #((table_q.size() + NUM_EXTRA) * (clk_gen_pkg::LOCK_CYCLES + 4) * MAX_PERIOD * 2 * CLK_NS);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic lfsr_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w          = {w[30:0], lfsr_state[0]};  // one step per bit taken
    end
  endtask

  function automatic void add(input string name, input int dom, input bit wr,
                              input logic [1:0] add_v, input logic [31:0] data,
                              input logic [31:0] exp, input logic [31:0] mask,
                              input int kind, input int post, input int period);
    entry_t e;
    e = '{name, dom, wr, add_v, data, exp, mask, kind, post, period};
    table_q.push_back(e);
  endfunction

  // starts at a falling edge and ends at the falling edge after ack
  task automatic cfg_access(input string name, input int dom, input bit wr,
                            input logic [1:0] add_v, input logic [31:0] data,
                            input logic [31:0] exp, input logic [31:0] mask, input bit chk);
    int cycles;
    if (chk) checker_i.arm_read(name, dom, exp, mask);
    req[dom] = '{req: 1'b1, wrn: wr, add: add_v, data: data};
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!rsp[dom].ack && cycles < 16);
    req[dom] = '0;  // dropped in the cycle after ack
    if (!rsp[dom].ack) checker_i.note_failure(name, "no ack within 16 cycles");
    else checker_i.check_value({name, "_ack_latency"}, 1, cycles);
    @(negedge clk);
    checker_i.check_value({name, "_ack_width"}, 0, rsp[dom].ack);
  endtask

  initial begin
    entry_t      e;
    logic [31:0] data;
    logic [31:0] exp;
    arst_n    = 1'b0;
    test_mode = 1'b0;
    for (int d = 0; d < 3; d++) req[d] = '0;

    add("rst_div", 0, 0, cfg_bus_pkg::ADDR_DIV, 0, clk_gen_pkg::DIV_RESET, '1, 0, 0, 0);
    add("rst_ctrl", 0, 0, cfg_bus_pkg::ADDR_CTRL, 0, clk_gen_pkg::EN_RESET, '1, 0, 0, 0);
    add("rst_status", 0, 0, cfg_bus_pkg::ADDR_STATUS, 0, 32'h2, 32'h2, 0, 0, 0);
    add("rst_div_per", 1, 0, cfg_bus_pkg::ADDR_DIV, 0, clk_gen_pkg::DIV_RESET, '1, 0, 0, 0);
    // all three words are written before any is read back, so aliased domains show up
    for (int d = 0; d < 3; d++) begin
      add($sformatf("scratch_wr_%0d", d), d, 1, cfg_bus_pkg::ADDR_SCRATCH, 0, 0, 0, 1, 0, 0);
    end
    for (int d = 0; d < 3; d++) begin
      add($sformatf("scratch_rd_%0d", d), d, 0, cfg_bus_pkg::ADDR_SCRATCH, 0, 0, '1, 2, 0, 0);
    end
    add("status_wr", 0, 1, cfg_bus_pkg::ADDR_STATUS, 0, 32'h2, 32'h2, 0, 0, 0);
    add("status_rd", 0, 0, cfg_bus_pkg::ADDR_STATUS, 0, 32'h2, 32'h2, 0, 0, 0);
    add("scratch_keep", 0, 0, cfg_bus_pkg::ADDR_SCRATCH, 0, 0, '1, 2, 0, 0);
    add("div_wr_soc", 0, 1, cfg_bus_pkg::ADDR_DIV, 3, 1, '1, 0, 1, 8);
    add("div_rd_soc", 0, 0, cfg_bus_pkg::ADDR_DIV, 0, 3, '1, 0, 0, 0);
    add("per_keeps", 1, 0, cfg_bus_pkg::ADDR_DIV, 0, 1, '1, 0, 1, 4);
    add("div_wr_cluster", 2, 1, cfg_bus_pkg::ADDR_DIV, 5, 1, '1, 0, 1, 12);
    add("soc_keeps", 0, 0, cfg_bus_pkg::ADDR_DIV, 0, 3, '1, 0, 1, 8);
    add("disable_soc", 0, 1, cfg_bus_pkg::ADDR_CTRL, 0, 1, '1, 0, 2, 0);
    add("disable_status", 0, 0, cfg_bus_pkg::ADDR_STATUS, 0, 0, 32'h3, 0, 0, 0);
    add("enable_soc", 0, 1, cfg_bus_pkg::ADDR_CTRL, 1, 0, '1, 0, 1, 8);
    table_ready = 1'b1;

    // both synchronized resets stay low while the global reset is held
    repeat (8) @(negedge clk);
    checker_i.check_value("rst_low_soc", 0, rstn_soc);
    checker_i.check_value("rst_low_cluster", 0, rstn_cluster);
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    checker_i.check_reset_release("rst_release");

    foreach (table_q[i]) begin
      e    = table_q[i];
      data = e.data;
      exp  = e.exp;
      if (e.kind == 1) begin
        lfsr_word(data);
        scratch_exp[e.dom] = data;
      end
      if (e.kind == 2) exp = scratch_exp[e.dom];
      cfg_access(e.name, e.dom, e.wr, e.add, data, exp, e.mask, e.kind != 1);
      if (e.post == 1) begin
        checker_i.wait_lock(e.name, e.dom, (clk_gen_pkg::LOCK_CYCLES + 2) * e.period);
        checker_i.measure_period({e.name, "_period"}, e.dom, e.period);
      end else if (e.post == 2) begin
        checker_i.check_low({e.name, "_low"}, e.dom, 64);
      end
    end

    // a short global reset pulse pulls both domain resets down at once
    @(negedge clk);
    arst_n = 1'b0;
    #1;
    checker_i.check_value("pulse_low_soc", 0, rstn_soc);
    checker_i.check_value("pulse_low_cluster", 0, rstn_cluster);
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    checker_i.check_reset_release("pulse_release");

    @(negedge clk);
    test_mode = 1'b1;
    checker_i.measure_period("tm_period_soc", 0, 1);
    checker_i.measure_period("tm_period_per", 1, 1);
    checker_i.measure_period("tm_period_cluster", 2, 1);
    cfg_access("tm_status", 0, 0, cfg_bus_pkg::ADDR_STATUS, 0, 1, 1, 1);
    arst_n = 1'b0;
    #1;
    checker_i.check_value("tm_rst_low_soc", 0, rstn_soc);
    checker_i.check_value("tm_rst_low_cluster", 0, rstn_cluster);
    @(negedge clk);
    arst_n = 1'b1;
    #1;
    checker_i.check_value("tm_rst_high_soc", 1, rstn_soc);
    checker_i.check_value("tm_rst_high_cluster", 1, rstn_cluster);
    @(negedge clk);

    checker_i.report();
    if (checker_i.fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
cfg_bus_pkg.sv
clk_gen_pkg.sv
fll_cfg_regs.sv
fll_clk_div.sv
clk_gen.sv
rstgen.sv
soc_clk_rst_gen.sv
tb_checker.sv
tb_soc_clk_rst_gen.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_soc_clk_rst_gen
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
